// File: hdl/rv_exec_cfg.svh
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// data and address width
`define RV_XLEN 32

// low target bits that must be zero for an aligned fetch
`define RV_ALIGN_BITS 2

// reinterpret a value as another type, e.g. a signed view of an operand
`define RV_CAST(t, x) t'(x)

`endif

// File: hdl/rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_cfg.svh"

package rv_exec_pkg;

    // alu operation codes, unlisted codes give all ones
    typedef enum logic [3:0] {
        ALU_OP_ADD  = 4'd0,
        ALU_OP_SUB  = 4'd1,
        ALU_OP_SLT  = 4'd2,
        ALU_OP_SLTU = 4'd3,
        ALU_OP_AND  = 4'd4,
        ALU_OP_OR   = 4'd5,
        ALU_OP_XOR  = 4'd6,
        ALU_OP_SLL  = 4'd7,
        ALU_OP_SRL  = 4'd8,
        ALU_OP_SRA  = 4'd9
    } alu_op_e;

    // control transfer kind, nine kinds need a fourth bit
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } br_kind_e;

    // overflow sits in bit 0, negative in bit 3
    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        logic                valid;
        alu_op_e             op;
        br_kind_e            br_kind;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
        // rs2 or immediate, picked by decode
        logic [`RV_XLEN-1:0] alu_b;
        logic [`RV_XLEN-1:0] imm;
        logic [4:0]          rd;
        logic                rd_we;
    } exec_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] res;
        alu_flags_t          flags;
    } alu_out_t;

    typedef struct packed {
        logic                taken;
        logic [`RV_XLEN-1:0] target;
        logic [`RV_XLEN-1:0] link;
        logic                misaligned;
    } br_out_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic                rd_we;
        logic [`RV_XLEN-1:0] wb_data;
        alu_flags_t          flags;
        logic                fault;
    } exec_resp_t;

endpackage

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module alu (
    input  logic [`RV_XLEN-1:0]  a,
    input  logic [`RV_XLEN-1:0]  b,
    input  rv_exec_pkg::alu_op_e op,
    output rv_exec_pkg::alu_out_t out
);
    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0]        b_op;
    logic                       cin;
    logic [`RV_XLEN:0]          sum_full;
    logic [`RV_XLEN-1:0]        s;
    logic                       co;
    logic                       sign;
    logic                       ov;
    logic                       ov_add;
    logic                       ov_sub;
    logic                       adder_op;
    logic [SHAMT_W-1:0]         shamt;
    logic signed [`RV_XLEN-1:0] signed_a;
    logic [`RV_XLEN-1:0]        res;

    assign signed_a = `RV_CAST(signed, a);
    assign shamt    = b[SHAMT_W-1:0];

    // operand select for the shared adder
    always_comb begin
        b_op = b;
        cin  = 1'b0;
        case (op)
            rv_exec_pkg::ALU_OP_SUB,
            rv_exec_pkg::ALU_OP_SLT,
            rv_exec_pkg::ALU_OP_SLTU: begin
                b_op = ~b;
                cin  = 1'b1;
            end
            default: begin
                b_op = b;
                cin  = 1'b0;
            end
        endcase
    end

    assign sum_full = {1'b0, a} + {1'b0, b_op} + {{`RV_XLEN{1'b0}}, cin};
    assign s        = sum_full[`RV_XLEN-1:0];
    assign co       = sum_full[`RV_XLEN];
    assign sign     = s[`RV_XLEN-1];

    // two positives giving a negative, or two negatives giving a positive
    assign ov_add = (~a[`RV_XLEN-1] & ~b[`RV_XLEN-1] &  s[`RV_XLEN-1])
                  | ( a[`RV_XLEN-1] &  b[`RV_XLEN-1] & ~s[`RV_XLEN-1]);

    // subtract flips the sign of b
    assign ov_sub = ( a[`RV_XLEN-1] & ~b[`RV_XLEN-1] & ~s[`RV_XLEN-1])
                  | (~a[`RV_XLEN-1] &  b[`RV_XLEN-1] &  s[`RV_XLEN-1]);

    always_comb begin
        case (op)
            rv_exec_pkg::ALU_OP_ADD: ov = ov_add;
            rv_exec_pkg::ALU_OP_SUB: ov = ov_sub;
            default:                 ov = 1'b0;
        endcase
    end

    // slt needs the sub overflow regardless of the op gating above
    always_comb begin
        case (op)
            rv_exec_pkg::ALU_OP_ADD:  res = s;
            rv_exec_pkg::ALU_OP_SUB:  res = s;
            rv_exec_pkg::ALU_OP_SLT:  res = {{(`RV_XLEN-1){1'b0}}, sign ^ ov_sub};
            rv_exec_pkg::ALU_OP_SLTU: res = {{(`RV_XLEN-1){1'b0}}, ~co};
            rv_exec_pkg::ALU_OP_AND:  res = a & b;
            rv_exec_pkg::ALU_OP_OR:   res = a | b;
            rv_exec_pkg::ALU_OP_XOR:  res = a ^ b;
            rv_exec_pkg::ALU_OP_SLL:  res = a << shamt;
            rv_exec_pkg::ALU_OP_SRL:  res = a >> shamt;
            rv_exec_pkg::ALU_OP_SRA:  res = `RV_CAST(unsigned, signed_a >>> shamt);
            default:                  res = '1;
        endcase
    end

    // add, sub, slt and sltu all go through the adder
    assign adder_op = (op == rv_exec_pkg::ALU_OP_ADD)
                    | (op == rv_exec_pkg::ALU_OP_SUB)
                    | (op == rv_exec_pkg::ALU_OP_SLT)
                    | (op == rv_exec_pkg::ALU_OP_SLTU);

    assign out.res            = res;
    assign out.flags.overflow = ov;
    assign out.flags.carry    = co & adder_op;
    assign out.flags.zero     = ~(|res);
    assign out.flags.negative = res[`RV_XLEN-1];

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module branch_unit (
    input  rv_exec_pkg::br_kind_e br_kind,
    input  logic [`RV_XLEN-1:0]   pc,
    input  logic [`RV_XLEN-1:0]   rs1_val,
    input  logic [`RV_XLEN-1:0]   rs2_val,
    input  logic [`RV_XLEN-1:0]   imm,
    output rv_exec_pkg::br_out_t  out
);
    logic                       eq;
    logic                       lt_s;
    logic                       lt_u;
    logic                       taken;
    logic [`RV_XLEN-1:0]        pc_target;
    logic [`RV_XLEN-1:0]        reg_target;
    logic [`RV_XLEN-1:0]        target;
    logic signed [`RV_XLEN-1:0] rs1_s;
    logic signed [`RV_XLEN-1:0] rs2_s;

    assign rs1_s = `RV_CAST(signed, rs1_val);
    assign rs2_s = `RV_CAST(signed, rs2_val);

    // compare results shared by all conditions
    assign eq   = (rs1_val == rs2_val);
    assign lt_s = (rs1_s < rs2_s);
    assign lt_u = (rs1_val < rs2_val);

    always_comb begin
        case (br_kind)
            rv_exec_pkg::BR_EQ:   taken = eq;
            rv_exec_pkg::BR_NE:   taken = ~eq;
            rv_exec_pkg::BR_LT:   taken = lt_s;
            rv_exec_pkg::BR_GE:   taken = ~lt_s;
            rv_exec_pkg::BR_LTU:  taken = lt_u;
            rv_exec_pkg::BR_GEU:  taken = ~lt_u;
            rv_exec_pkg::BR_JAL:  taken = 1'b1;
            rv_exec_pkg::BR_JALR: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    assign pc_target = pc + imm;

    // jalr drops bit 0 of the sum
    assign reg_target = (rs1_val + imm) & ~{{(`RV_XLEN-1){1'b0}}, 1'b1};

    assign target = (br_kind == rv_exec_pkg::BR_JALR) ? reg_target : pc_target;

    assign out.taken  = taken;
    assign out.target = target;
    assign out.link   = pc + {{(`RV_XLEN-3){1'b0}}, 3'd4};

    // only a transfer that is taken can fault
    assign out.misaligned = taken & (|target[`RV_ALIGN_BITS-1:0]);

endmodule

`default_nettype wire

// File: hdl/exec_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module exec_writeback (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    valid,
    input  logic [4:0]              rd,
    input  logic                    rd_we,
    input  rv_exec_pkg::br_kind_e   br_kind,
    input  rv_exec_pkg::alu_out_t   alu_res,
    input  rv_exec_pkg::br_out_t    br_res,
    output rv_exec_pkg::exec_resp_t resp,
    output logic                    redirect,
    output logic [`RV_XLEN-1:0]     redirect_pc
);
    logic                    is_jump;
    logic                    is_cond;
    logic                    fault_d;
    logic                    redirect_d;
    logic                    we_d;
    logic [`RV_XLEN-1:0]     wb_data_d;

    logic                    valid_q;
    logic                    we_q;
    logic                    fault_q;
    logic                    redirect_q;
    logic [4:0]              rd_q;
    logic [`RV_XLEN-1:0]     wb_data_q;
    logic [`RV_XLEN-1:0]     redirect_pc_q;
    rv_exec_pkg::alu_flags_t flags_q;

    assign is_jump = (br_kind == rv_exec_pkg::BR_JAL) | (br_kind == rv_exec_pkg::BR_JALR);
    assign is_cond = (br_kind != rv_exec_pkg::BR_NONE) & ~is_jump;

    // misaligned taken transfer faults instead of redirecting
    assign fault_d    = valid & br_res.taken & br_res.misaligned;
    assign redirect_d = valid & br_res.taken & ~br_res.misaligned;

    // x0 is never written
    assign we_d = valid & rd_we & ~is_cond & ~fault_d & (rd != 5'd0);

    assign wb_data_d = is_jump ? br_res.link : alu_res.res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= 1'b0;
            we_q       <= 1'b0;
            fault_q    <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            valid_q    <= valid;
            we_q       <= we_d;
            fault_q    <= fault_d;
            redirect_q <= redirect_d;
        end
    end

    // payload, qualified by the control bits above
    always_ff @(posedge clk) begin
        rd_q          <= rd;
        wb_data_q     <= wb_data_d;
        flags_q       <= alu_res.flags;
        redirect_pc_q <= br_res.target;
    end

    always_comb begin
        resp.valid   = valid_q;
        resp.rd      = rd_q;
        resp.rd_we   = we_q;
        resp.wb_data = wb_data_q;
        resp.flags   = flags_q;
        resp.fault   = fault_q;
    end

    assign redirect    = redirect_q;
    assign redirect_pc = redirect_pc_q;

endmodule

`default_nettype wire

// File: hdl/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module exec_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_exec_pkg::exec_req_t  req,
    output rv_exec_pkg::exec_resp_t resp,
    output logic                    redirect,
    output logic [`RV_XLEN-1:0]     redirect_pc
);
    rv_exec_pkg::alu_out_t alu_res;
    rv_exec_pkg::br_out_t  br_res;

    // alu and branch unit see the same request in parallel
    alu u_alu (
        .a   (req.rs1_val),
        .b   (req.alu_b),
        .op  (req.op),
        .out (alu_res)
    );

    branch_unit u_branch_unit (
        .br_kind (req.br_kind),
        .pc      (req.pc),
        .rs1_val (req.rs1_val),
        .rs2_val (req.rs2_val),
        .imm     (req.imm),
        .out     (br_res)
    );

    // single register stage, one cycle latency
    exec_writeback u_exec_writeback (
        .clk         (clk),
        .arst_n      (arst_n),
        .valid       (req.valid),
        .rd          (req.rd),
        .rd_we       (req.rd_we),
        .br_kind     (req.br_kind),
        .alu_res     (alu_res),
        .br_res      (br_res),
        .resp        (resp),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

// File: dv/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module exec_stage_tb;
    localparam int N_RAND       = 20;
    localparam int STIM_CYCLES  = 4 + 100 + 10 * N_RAND + 6 + 30 + 12 + 4 + 9 + 2;
    localparam int CYCLE_LIMIT  = 2 * (STIM_CYCLES + 13);

    logic                    clk = 1'b0;
    logic                    arst_n = 1'b1;
    rv_exec_pkg::exec_req_t  req;
    rv_exec_pkg::exec_resp_t resp;
    logic                    redirect;
    logic [`RV_XLEN-1:0]     redirect_pc;

    // expected outputs, valid around the next rising edge
    rv_exec_pkg::exec_resp_t exp_resp;
    logic                    exp_redirect;
    logic [`RV_XLEN-1:0]     exp_pc;
    string                   exp_name;

    // one-deep model register: request the DUT captured last
    rv_exec_pkg::exec_req_t  req_prev;
    string                   prev_name;
    string                   cur_test;

    integer                  seed = 32'ha4069209;
    int                      cycle_cnt = 0;

    exec_stage dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .resp        (resp),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial forever #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic report_mismatch(input string field, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("Mismatch in test %s, %s: expected 0x%08h, actual 0x%08h",
                 exp_name, field, expv, actv);
        $display("TESTS FAILED");
        $fatal(1, "response check failed");
    endtask

    valid_check: assert property (@(posedge clk) resp.valid == exp_resp.valid)
        else report_mismatch("resp.valid", 32'(exp_resp.valid), 32'($sampled(resp.valid)));
    we_check: assert property (@(posedge clk) resp.rd_we == exp_resp.rd_we)
        else report_mismatch("resp.rd_we", 32'(exp_resp.rd_we), 32'($sampled(resp.rd_we)));
    fault_check: assert property (@(posedge clk) resp.fault == exp_resp.fault)
        else report_mismatch("resp.fault", 32'(exp_resp.fault), 32'($sampled(resp.fault)));
    redirect_check: assert property (@(posedge clk) redirect == exp_redirect)
        else report_mismatch("redirect", 32'(exp_redirect), 32'($sampled(redirect)));
    rd_check: assert property (@(posedge clk) exp_resp.valid |-> resp.rd == exp_resp.rd)
        else report_mismatch("resp.rd", 32'(exp_resp.rd), 32'($sampled(resp.rd)));
    data_check: assert property (@(posedge clk)
        exp_resp.valid |-> resp.wb_data == exp_resp.wb_data)
        else report_mismatch("resp.wb_data", exp_resp.wb_data, $sampled(resp.wb_data));
    flags_check: assert property (@(posedge clk)
        exp_resp.valid |-> resp.flags == exp_resp.flags)
        else report_mismatch("resp.flags", 32'(exp_resp.flags), 32'($sampled(resp.flags)));
    pc_check: assert property (@(posedge clk) exp_redirect |-> redirect_pc == exp_pc)
        else report_mismatch("redirect_pc", exp_pc, $sampled(redirect_pc));

    function automatic rv_exec_pkg::alu_out_t alu_model(input rv_exec_pkg::alu_op_e op,
                                                        input logic [31:0] a,
                                                        input logic [31:0] b);
        rv_exec_pkg::alu_out_t o;
        logic [32:0]           sum;
        logic [32:0]           diff;
        logic [31:0]           r;
        sum  = {1'b0, a} + {1'b0, b};
        diff = {1'b0, a} + {1'b0, ~b} + 33'd1;
        o.flags.overflow = 1'b0;
        o.flags.carry    = 1'b0;
        case (op)
            rv_exec_pkg::ALU_OP_ADD: begin
                r = sum[31:0];
                o.flags.carry    = sum[32];
                o.flags.overflow = (a[31] == b[31]) && (r[31] != a[31]);
            end
            rv_exec_pkg::ALU_OP_SUB: begin
                r = diff[31:0];
                o.flags.carry    = diff[32];
                o.flags.overflow = (a[31] != b[31]) && (r[31] != a[31]);
            end
            rv_exec_pkg::ALU_OP_SLT: begin
                r = {31'd0, $signed(a) < $signed(b)};
                o.flags.carry = diff[32];
            end
            rv_exec_pkg::ALU_OP_SLTU: begin
                r = {31'd0, a < b};
                o.flags.carry = diff[32];
            end
            rv_exec_pkg::ALU_OP_AND: r = a & b;
            rv_exec_pkg::ALU_OP_OR:  r = a | b;
            rv_exec_pkg::ALU_OP_XOR: r = a ^ b;
            rv_exec_pkg::ALU_OP_SLL: r = a << b[4:0];
            rv_exec_pkg::ALU_OP_SRL: r = a >> b[4:0];
            rv_exec_pkg::ALU_OP_SRA: r = $signed(a) >>> b[4:0];
            default:                 r = 32'hffff_ffff;
        endcase
        o.res            = r;
        o.flags.zero     = (r == 32'd0);
        o.flags.negative = r[31];
        return o;
    endfunction

    function automatic logic branch_taken(input rv_exec_pkg::br_kind_e kind,
                                          input logic [31:0] x, input logic [31:0] y);
        case (kind)
            rv_exec_pkg::BR_EQ:   return x == y;
            rv_exec_pkg::BR_NE:   return x != y;
            rv_exec_pkg::BR_LT:   return $signed(x) < $signed(y);
            rv_exec_pkg::BR_GE:   return $signed(x) >= $signed(y);
            rv_exec_pkg::BR_LTU:  return x < y;
            rv_exec_pkg::BR_GEU:  return x >= y;
            rv_exec_pkg::BR_JAL:  return 1'b1;
            rv_exec_pkg::BR_JALR: return 1'b1;
            default:              return 1'b0;
        endcase
    endfunction

    task automatic predict(input rv_exec_pkg::exec_req_t r);
        rv_exec_pkg::alu_out_t a_out;
        logic                  jump;
        logic                  cond;
        logic                  taken;
        logic                  misal;
        logic [31:0]           target;
        a_out = alu_model(r.op, r.rs1_val, r.alu_b);
        jump  = (r.br_kind == rv_exec_pkg::BR_JAL) || (r.br_kind == rv_exec_pkg::BR_JALR);
        cond  = !jump && (r.br_kind != rv_exec_pkg::BR_NONE);
        taken = r.valid && branch_taken(r.br_kind, r.rs1_val, r.rs2_val);
        if (r.br_kind == rv_exec_pkg::BR_JALR)
            target = (r.rs1_val + r.imm) & ~32'd1;
        else
            target = r.pc + r.imm;
        misal = taken && (target[`RV_ALIGN_BITS-1:0] != '0);
        exp_resp.valid   = r.valid;
        exp_resp.rd      = r.rd;
        exp_resp.rd_we   = r.valid && r.rd_we && !cond && !misal && (r.rd != 5'd0);
        exp_resp.wb_data = jump ? r.pc + 32'd4 : a_out.res;
        exp_resp.flags   = a_out.flags;
        exp_resp.fault   = misal;
        exp_redirect     = taken && !misal;
        exp_pc           = target;
    endtask

    function automatic rv_exec_pkg::exec_req_t idle_req();
        rv_exec_pkg::exec_req_t r;
        r = '0;
        return r;
    endfunction

    function automatic rv_exec_pkg::exec_req_t make_req(
        input rv_exec_pkg::alu_op_e op, input rv_exec_pkg::br_kind_e kind,
        input logic [31:0] pc, input logic [31:0] rs1, input logic [31:0] rs2,
        input logic [31:0] imm, input logic [4:0] rd);
        rv_exec_pkg::exec_req_t r;
        r.valid   = 1'b1;
        r.op      = op;
        r.br_kind = kind;
        r.pc      = pc;
        r.rs1_val = rs1;
        r.rs2_val = rs2;
        r.alu_b   = rs2;
        r.imm     = imm;
        r.rd      = rd;
        r.rd_we   = 1'b1;
        return r;
    endfunction

    // one request per falling edge, expected values move along with it
    task automatic drive(input rv_exec_pkg::exec_req_t r);
        @(negedge clk);
        predict(req_prev);
        exp_name  = prev_name;
        req_prev  = r;
        prev_name = cur_test;
        req       = r;
    endtask

    task automatic reset_dut(input int cycles);
        arst_n   = 1'b0;
        // whatever was in flight is dropped
        req_prev  = idle_req();
        exp_name  = cur_test;
        prev_name = cur_test;
        predict(req_prev);
        #1;
        assert (!resp.valid && !redirect && !resp.rd_we && !resp.fault) else begin
            $display("Error: outputs were not cleared as soon as reset was asserted");
            $display("TESTS FAILED");
            $fatal(1, "reset check failed");
        end
        repeat (cycles) drive(idle_req());
        arst_n = 1'b1;
    endtask

    task automatic arith_ops();
        logic [31:0]          corner [5];
        rv_exec_pkg::alu_op_e ops [4];
        logic [31:0]          x;
        logic [31:0]          y;
        corner = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        ops = '{rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::ALU_OP_SUB,
                rv_exec_pkg::ALU_OP_SLT, rv_exec_pkg::ALU_OP_SLTU};
        cur_test = "arith corners";
        foreach (ops[k])
            foreach (corner[i])
                foreach (corner[j])
                    drive(make_req(ops[k], rv_exec_pkg::BR_NONE, 32'h100, corner[i],
                                   corner[j], 32'h0, 5'd3));
        cur_test = "arith random";
        foreach (ops[k])
            repeat (N_RAND) begin
                x = $random(seed);
                y = $random(seed);
                drive(make_req(ops[k], rv_exec_pkg::BR_NONE, 32'h200, x, y, 32'h0,
                               x[4:0] | 5'd1));
            end
    endtask

    task automatic logic_and_shift_ops();
        logic [31:0] x;
        logic [31:0] y;
        cur_test = "logic and shift";
        for (int k = 4; k <= 9; k++)
            for (int n = 0; n < N_RAND; n++) begin
                x = $random(seed);
                y = $random(seed);
                // shift amount with the upper bits of b set
                if (n % 2 == 0)
                    y = y | 32'hffff_ffe0;
                drive(make_req(rv_exec_pkg::alu_op_e'(4'(k)), rv_exec_pkg::BR_NONE,
                               32'h300, x, y, 32'h0, 5'd9));
            end
        cur_test = "unused op";
        for (int k = 10; k <= 15; k++) begin
            x = $random(seed);
            y = $random(seed);
            drive(make_req(rv_exec_pkg::alu_op_e'(4'(k)), rv_exec_pkg::BR_NONE,
                           32'h400, x, y, 32'h0, 5'd10));
        end
    endtask

    task automatic conditional_branches();
        logic [31:0] lhs [5];
        logic [31:0] rhs [5];
        logic [31:0] rnd;
        lhs = '{32'd5, 32'd3, 32'd7, 32'hffff_ffff, 32'd1};
        rhs = '{32'd5, 32'd7, 32'd3, 32'd1, 32'hffff_ffff};
        cur_test = "conditional branch";
        for (int k = 1; k <= 6; k++)
            foreach (lhs[i]) begin
                rnd = $random(seed);
                drive(make_req(rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::br_kind_e'(4'(k)),
                               {rnd[31:2], 2'b00}, lhs[i], rhs[i],
                               {{20{rnd[11]}}, rnd[11:2], 2'b00}, 5'd4));
            end
    endtask

    task automatic jump_ops();
        logic [31:0] p;
        logic [31:0] s;
        cur_test = "jump directed";
        drive(make_req(rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::BR_JAL, 32'h1000, 32'h5,
                       32'h6, 32'h40, 5'd5));
        drive(make_req(rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::BR_JALR, 32'h1100,
                       32'h0000_1001, 32'h0, 32'h10, 5'd7));
        drive(make_req(rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::BR_JAL, 32'h1200, 32'h1,
                       32'h2, 32'h80, 5'd0));
        drive(make_req(rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::BR_JALR, 32'h1300,
                       32'h0000_2000, 32'h0, 32'h20, 5'd0));
        cur_test = "jump random";
        for (int n = 0; n < 8; n++) begin
            p = $random(seed);
            s = $random(seed);
            drive(make_req(rv_exec_pkg::ALU_OP_ADD,
                           (n % 2 == 0) ? rv_exec_pkg::BR_JAL : rv_exec_pkg::BR_JALR,
                           {p[31:2], 2'b00}, s & ~32'h2, p, {s[23:2], 2'b00} & 32'h0fff_fffc,
                           s[4:0] | 5'd1));
        end
    endtask

    task automatic misaligned_targets();
        cur_test = "misaligned target";
        drive(make_req(rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::BR_JAL, 32'h3000, 32'h0,
                       32'h0, 32'h6, 5'd6));
        drive(make_req(rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::BR_EQ, 32'h3100, 32'h9,
                       32'h9, 32'ha, 5'd6));
        drive(make_req(rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::BR_JALR, 32'h3200,
                       32'h0000_2000, 32'h0, 32'h3, 5'd6));
        // not taken, so the odd target does not matter
        drive(make_req(rv_exec_pkg::ALU_OP_ADD, rv_exec_pkg::BR_NE, 32'h3300, 32'h9,
                       32'h9, 32'h6, 5'd6));
    endtask

    task automatic reset_in_stream();
        logic [31:0]           x;
        logic [31:0]           y;
        rv_exec_pkg::br_kind_e kind;
        cur_test = "stream before reset";
        for (int n = 0; n < 6; n++) begin
            x = $random(seed);
            y = $random(seed);
            // last one is a jump so redirect and rd_we are high when reset hits
            if (n == 5)
                kind = rv_exec_pkg::BR_JAL;
            else if (n % 2 == 0)
                kind = rv_exec_pkg::BR_NE;
            else
                kind = rv_exec_pkg::BR_NONE;
            drive(make_req(rv_exec_pkg::ALU_OP_XOR, kind, 32'h4000, x, y, 32'h8, 5'd12));
        end
        @(posedge clk);
        #5;
        cur_test = "reset mid stream";
        reset_dut(3);
        cur_test = "idle after reset";
        repeat (3) drive(idle_req());
    endtask

    initial begin
        req       = '0;
        req_prev  = '0;
        exp_resp  = '0;
        exp_redirect = 1'b0;
        exp_pc    = '0;
        exp_name  = "reset";
        prev_name = "reset";
        cur_test  = "reset";
        reset_dut(10);
        cur_test = "idle after reset";
        repeat (4) drive(idle_req());
        arith_ops();
        logic_and_shift_ops();
        conditional_branches();
        jump_ops();
        misaligned_targets();
        reset_in_stream();
        cur_test = "drain";
        repeat (2) drive(idle_req());
        @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/rv_exec_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/exec_writeback.sv
hdl/exec_stage.sv
dv/exec_stage_tb.sv

// File: Makefile
# Verilator build for the execute stage

SIM_BIN := sim_exec_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module exec_stage

sim:
	verilator --binary --timing --assert -f files.f \
		--top-module exec_stage_tb -o $(SIM_BIN)
	./obj_dir/$(SIM_BIN)

clean:
	rm -rf obj_dir
